/* project.f */
+incdir+common
common/csr_access_pkg.sv
common/csr_trap_pkg.sv
csr/csr_machine_regs.sv
csr/csr_counters.sv
csr/csr_access.sv
rtl/rv32_csrs.sv
verif/csr_tb.sv

/* Makefile */
# Verilator build, run and lint for the CSR block.

TOP = csr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f project.f --top-module rv32_csrs

clean:
	rm -rf obj_dir sim.log

/* verif/csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_tb;
    import csr_access_pkg::*;
    import csr_trap_pkg::*;

    typedef enum logic [2:0] {
        K_READ, K_WRITE, K_ECALL, K_EBREAK, K_MRET, K_RETIRE
    } kind_t;

    typedef enum logic [1:0] {
        HOLD_NONE, HOLD_STALL, HOLD_FLUSH, HOLD_WB_FLUSH
    } hold_t;

    typedef struct packed {
        kind_t         kind;
        logic [11:0]   addr;
        csr_write_op_t op;
        csr_src_t      src;
        logic          use_lfsr;  // Data from the LFSR instead of the fixed value.
        logic [31:0]   data;
        hold_t         hold;
    } entry_t;

    localparam logic [11:0] RESET_READS [22] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
        `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL,
        `CSR_ADDR_MIP, 12'h7C0, 12'hB03, 12'hB83, 12'h323, 12'h3A0, 12'h3B0,
        12'hF11, 12'hF14, `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE, `CSR_ADDR_TIME,
        `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET
    };
    localparam logic [11:0] MACHINE_REGS [7] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL
    };
    localparam logic [11:0] WRITE_TARGETS [5] = '{
        `CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVAL, `CSR_ADDR_MTVEC, `CSR_ADDR_MIE, `CSR_ADDR_MSTATUS
    };

    logic          clk;
    logic          reset;
    logic          stall;
    logic          flush;
    logic          writeback_flush;
    logic          write;
    csr_write_op_t write_op;
    csr_src_t      src;
    logic          ecall;
    logic          ebreak;
    logic          mret;
    logic          instr_retired;
    logic [31:0]   pc;
    csr_addr_t     csr;
    logic [31:0]   rs1_value;
    logic [31:0]   imm_value;
    logic          trap;
    logic [31:0]   read_value;
    logic [31:0]   trap_pc;
    logic [63:0]   cycle;

    // Reference model state, kept as architectural words.
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [63:0] elapsed;
    logic [63:0] retired;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    entry_t      table_q [$];

    rv32_csrs dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // The first cycle after reset release counts as cycle 0.
    always @(posedge clk) begin
        if (reset) begin
            elapsed <= '0;
        end else begin
            elapsed <= elapsed + 64'd1;
        end
    end

    // ##############################
    // Model and stimulus helpers
    // ##############################

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};  // One step per bit.
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_read(input logic [11:0] addr);
        logic [31:0] w;
        w = '0;
        case (addr)
            `CSR_ADDR_MSTATUS: begin
                w = m_mstatus;
                w[`CSR_BIT_MPP_LO +: 2] = `CSR_MSTATUS_MPP;
            end
            `CSR_ADDR_MISA:     w = `CSR_MISA_VALUE;
            `CSR_ADDR_MIE:      w = m_mie;
            `CSR_ADDR_MTVEC:    w = m_mtvec;
            `CSR_ADDR_MSCRATCH: w = m_mscratch;
            `CSR_ADDR_MEPC:     w = m_mepc;
            `CSR_ADDR_MCAUSE:   w = m_mcause;
            `CSR_ADDR_MTVAL:    w = m_mtval;
            `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE, `CSR_ADDR_TIME:    w = elapsed[31:0];
            `CSR_ADDR_MCYCLEH, `CSR_ADDR_CYCLEH, `CSR_ADDR_TIMEH: w = elapsed[63:32];
            `CSR_ADDR_MINSTRET, `CSR_ADDR_INSTRET:   w = retired[31:0];
            `CSR_ADDR_MINSTRETH, `CSR_ADDR_INSTRETH: w = retired[63:32];
            default:            w = '0;
        endcase
        return w;
    endfunction

    function automatic void apply_write(input logic [11:0] addr, input csr_write_op_t op,
                                        input logic [31:0] operand);
        logic [31:0] old;
        logic [31:0] nv;
        old = expected_read(addr);
        case (op)
            CSR_OP_RW: nv = operand;
            CSR_OP_RS: nv = old | operand;
            default:   nv = old & ~operand;
        endcase
        case (addr)
            `CSR_ADDR_MSTATUS:  m_mstatus  = nv & 32'h0000_0088;  // MPIE and MIE.
            `CSR_ADDR_MIE:      m_mie      = nv & 32'h0000_0888;
            `CSR_ADDR_MTVEC:    m_mtvec    = nv & 32'hFFFF_FFFD;
            `CSR_ADDR_MSCRATCH: m_mscratch = nv;
            `CSR_ADDR_MEPC:     m_mepc     = nv & 32'hFFFF_FFFC;
            `CSR_ADDR_MCAUSE:   m_mcause   = nv & 32'h8000_000F;
            `CSR_ADDR_MTVAL:    m_mtval    = nv;
            default: ;
        endcase
    endfunction

    task automatic add_entry(input kind_t kind, input logic [11:0] addr,
                             input csr_write_op_t op, input csr_src_t source,
                             input logic use_lfsr, input logic [31:0] data, input hold_t hold);
        entry_t e;
        e.kind     = kind;
        e.addr     = addr;
        e.op       = op;
        e.src      = source;
        e.use_lfsr = use_lfsr;
        e.data     = data;
        e.hold     = hold;
        table_q.push_back(e);
    endtask

    task automatic add_op(input kind_t kind, input logic [11:0] addr, input hold_t hold);
        add_entry(kind, addr, CSR_OP_RW, CSR_SRC_REG, 1'b1, 32'h0, hold);
    endtask

    task automatic start_cycle();
        @(posedge clk);
        #0.5;
        write           = 1'b0;
        ecall           = 1'b0;
        ebreak          = 1'b0;
        mret            = 1'b0;
        instr_retired   = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        writeback_flush = 1'b0;
    endtask

    // ##############################
    // Checks
    // ##############################

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h at %0t", name, expected, got, $time);
        end
    endtask

    task automatic check_cycle();
        checks++;
        if (cycle !== elapsed) begin
            errors++;
            $display("FAILED cycle: expected %h, got %h at %0t", elapsed, cycle, $time);
        end
    endtask

    task automatic check_trap(input logic expected, input logic [31:0] expected_pc);
        checks++;
        if (trap !== expected) begin
            errors++;
            $display("FAILED trap: expected %h, got %h at %0t", expected, trap, $time);
        end else if (expected) begin
            check_word("trap_pc", trap_pc, expected_pc);
        end
    endtask

    task automatic check_read(input logic [11:0] addr);
        start_cycle();
        csr = csr_addr_t'(addr);
        #1;
        check_cycle();
        check_word($sformatf("read_value[csr %h]", addr), read_value, expected_read(addr));
        check_trap(1'b0, 32'h0);
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] value;
        logic [31:0] other;
        logic        blocked;
        logic        redirect;
        logic [31:0] target;
        value    = e.use_lfsr ? random_word() : e.data;
        other    = random_word();
        blocked  = (e.hold == HOLD_STALL) || (e.hold == HOLD_FLUSH);
        redirect = !blocked && (e.kind inside {K_ECALL, K_EBREAK, K_MRET});
        target   = (e.kind == K_MRET) ? m_mepc : (m_mtvec & 32'hFFFF_FFFC);

        start_cycle();
        stall           = (e.hold == HOLD_STALL);
        flush           = (e.hold == HOLD_FLUSH);
        writeback_flush = (e.hold == HOLD_WB_FLUSH);
        csr             = csr_addr_t'(e.addr);
        write_op        = e.op;
        src             = e.src;
        write           = (e.kind == K_WRITE);
        ecall           = (e.kind == K_ECALL);
        ebreak          = (e.kind == K_EBREAK);
        mret            = (e.kind == K_MRET);
        instr_retired   = (e.kind == K_RETIRE);
        pc              = value;
        rs1_value       = (e.src == CSR_SRC_REG) ? value : other;  // The unused source is noise.
        imm_value       = (e.src == CSR_SRC_REG) ? other : value;
        #1;
        check_cycle();
        check_word($sformatf("read_value[csr %h]", e.addr), read_value, expected_read(e.addr));
        check_trap(redirect, target);

        // Commit in the model what the coming edge commits in the DUT.
        if (!blocked) begin
            case (e.kind)
                K_WRITE: apply_write(e.addr, e.op, value);
                K_ECALL, K_EBREAK: begin
                    m_mepc   = value & 32'hFFFF_FFFC;
                    m_mcause = (e.kind == K_ECALL) ? 32'(CAUSE_MACHINE_ECALL)
                                                   : 32'(CAUSE_BREAKPOINT);
                end
                K_MRET: begin
                    m_mstatus[`CSR_BIT_MIE]  = m_mstatus[`CSR_BIT_MPIE];
                    m_mstatus[`CSR_BIT_MPIE] = 1'b1;
                end
                K_RETIRE: begin
                    if (e.hold != HOLD_WB_FLUSH) begin
                        retired = retired + 64'd1;
                    end
                end
                default: ;
            endcase
        end

        if (blocked) begin
            foreach (MACHINE_REGS[i]) check_read(MACHINE_REGS[i]);
        end else begin
            case (e.kind)
                K_WRITE: check_read(e.addr);
                K_ECALL, K_EBREAK: begin
                    check_read(`CSR_ADDR_MEPC);
                    check_read(`CSR_ADDR_MCAUSE);
                end
                K_MRET: check_read(`CSR_ADDR_MSTATUS);
                K_RETIRE: begin
                    check_read(`CSR_ADDR_MINSTRET);
                    check_read(`CSR_ADDR_INSTRET);
                    check_read(`CSR_ADDR_MINSTRETH);
                    check_read(`CSR_ADDR_INSTRETH);
                end
                default: ;
            endcase
        end
    endtask

    // ##############################
    // Stimulus table
    // ##############################

    task automatic build_table();
        foreach (RESET_READS[i]) add_op(K_READ, RESET_READS[i], HOLD_NONE);
        foreach (WRITE_TARGETS[t]) begin
            for (int o = 0; o < 3; o++) begin
                for (int s = 0; s < 2; s++) begin
                    add_entry(K_WRITE, WRITE_TARGETS[t], csr_write_op_t'(o[1:0]),
                              csr_src_t'(s[0]), 1'b1, 32'h0, HOLD_NONE);
                end
            end
        end
        add_op(K_WRITE, `CSR_ADDR_MEPC, HOLD_NONE);
        add_op(K_WRITE, `CSR_ADDR_MCAUSE, HOLD_NONE);
        add_op(K_WRITE, `CSR_ADDR_MCYCLE, HOLD_NONE);  // Counters ignore writes.
        add_entry(K_WRITE, `CSR_ADDR_MISA, CSR_OP_RW, CSR_SRC_IMM, 1'b0, 32'hFFFF_FFFF,
                  HOLD_NONE);
        add_op(K_ECALL, `CSR_ADDR_MTVEC, HOLD_NONE);
        add_op(K_EBREAK, `CSR_ADDR_MTVEC, HOLD_NONE);

        // mret with MPIE set, then with MPIE clear, then once more.
        add_entry(K_WRITE, `CSR_ADDR_MSTATUS, CSR_OP_RW, CSR_SRC_IMM, 1'b0, 32'h80, HOLD_NONE);
        add_op(K_MRET, `CSR_ADDR_MSTATUS, HOLD_NONE);
        add_entry(K_WRITE, `CSR_ADDR_MSTATUS, CSR_OP_RW, CSR_SRC_IMM, 1'b0, 32'h08, HOLD_NONE);
        add_op(K_MRET, `CSR_ADDR_MSTATUS, HOLD_NONE);
        add_op(K_ECALL, `CSR_ADDR_MEPC, HOLD_NONE);
        add_op(K_MRET, `CSR_ADDR_MSTATUS, HOLD_NONE);

        add_op(K_WRITE, `CSR_ADDR_MSCRATCH, HOLD_STALL);
        add_entry(K_WRITE, `CSR_ADDR_MTVAL, CSR_OP_RS, CSR_SRC_REG, 1'b1, 32'h0, HOLD_FLUSH);
        add_op(K_ECALL, `CSR_ADDR_MTVEC, HOLD_STALL);
        add_op(K_EBREAK, `CSR_ADDR_MTVEC, HOLD_FLUSH);
        add_op(K_MRET, `CSR_ADDR_MSTATUS, HOLD_STALL);
        add_op(K_MRET, `CSR_ADDR_MSTATUS, HOLD_FLUSH);

        for (int r = 0; r < 7; r++) begin
            if (r % 3 == 2) begin
                add_op(K_RETIRE, `CSR_ADDR_MINSTRET, HOLD_WB_FLUSH);
            end else begin
                add_op(K_RETIRE, `CSR_ADDR_MINSTRET, HOLD_NONE);
            end
        end
        add_op(K_READ, `CSR_ADDR_CYCLE, HOLD_NONE);
        add_op(K_READ, `CSR_ADDR_TIME, HOLD_NONE);
        add_op(K_READ, `CSR_ADDR_CYCLEH, HOLD_NONE);
        add_op(K_READ, `CSR_ADDR_TIMEH, HOLD_NONE);
    endtask

    initial begin
        int wait_cycles;
        reset           = 1'b1;
        stall           = 1'b0;
        flush           = 1'b0;
        writeback_flush = 1'b0;
        write           = 1'b0;
        write_op        = CSR_OP_RW;
        src             = CSR_SRC_IMM;
        ecall           = 1'b0;
        ebreak          = 1'b0;
        mret            = 1'b0;
        instr_retired   = 1'b0;
        pc              = '0;
        csr             = CSR_MSTATUS;
        rs1_value       = '0;
        imm_value       = '0;
        m_mstatus       = '0;
        m_mie           = '0;
        m_mtvec         = '0;
        m_mscratch      = '0;
        m_mepc          = '0;
        m_mcause        = '0;
        m_mtval         = '0;
        retired         = '0;
        lfsr            = 32'h0e15ef53;
        errors          = 0;
        checks          = 0;
        build_table();

        repeat (3) @(posedge clk);
        #0.5;
        reset = 1'b0;
        #1;
        wait_cycles = 0;
        while (cycle !== 64'd0 && wait_cycles < 10) begin
            @(posedge clk);
            #1.5;
            wait_cycles++;
        end

        if (cycle !== 64'd0) begin
            $display("Timed out waiting for the cycle counter to leave reset");
            $display("Simulation failed");
            $finish;
        end else begin
            foreach (table_q[i]) run_entry(table_q[i]);
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv32_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module rv32_csrs (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          stall,
    input  wire logic                          flush,
    input  wire logic                          writeback_flush,

    input  wire logic                          write,
    input  wire csr_access_pkg::csr_write_op_t write_op,
    input  wire csr_access_pkg::csr_src_t      src,
    input  wire logic                          ecall,
    input  wire logic                          ebreak,
    input  wire logic                          mret,
    input  wire logic                          instr_retired,

    input  wire logic [`CSR_XLEN-1:0]          pc,
    input  wire csr_access_pkg::csr_addr_t     csr,
    input  wire logic [`CSR_XLEN-1:0]          rs1_value,
    input  wire logic [`CSR_XLEN-1:0]          imm_value,

    output logic                               trap,
    output logic [`CSR_XLEN-1:0]               read_value,
    output logic [`CSR_XLEN-1:0]               trap_pc,
    output logic [`CSR_COUNTER_W-1:0]          cycle
);
    import csr_trap_pkg::*;

    logic [`CSR_XLEN-1:0]      new_value;
    logic                      mstatus_mie;
    logic                      mstatus_mpie;
    logic [2:0]                mie_bits;
    logic [`CSR_XLEN-1:2]      mtvec_base;
    mtvec_mode_t               mtvec_mode;
    logic [`CSR_XLEN-1:0]      mscratch;
    logic [`CSR_XLEN-1:2]      mepc;
    logic                      mcause_interrupt;
    mcause_code_t              mcause_code;
    logic [`CSR_XLEN-1:0]      mtval;
    logic [`CSR_COUNTER_W-1:0] instret;

    csr_machine_regs u_machine_regs (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .flush            (flush),
        .write            (write),
        .ecall            (ecall),
        .ebreak           (ebreak),
        .mret             (mret),
        .csr              (csr),
        .new_value        (new_value),
        .pc               (pc),
        .mstatus_mie      (mstatus_mie),
        .mstatus_mpie     (mstatus_mpie),
        .mie_bits         (mie_bits),
        .mtvec_base       (mtvec_base),
        .mtvec_mode       (mtvec_mode),
        .mscratch         (mscratch),
        .mepc             (mepc),
        .mcause_interrupt (mcause_interrupt),
        .mcause_code      (mcause_code),
        .mtval            (mtval),
        .trap             (trap),
        .trap_pc          (trap_pc)
    );

    csr_counters u_counters (
        .clk              (clk),
        .reset            (reset),
        .instr_retired    (instr_retired),
        .writeback_flush  (writeback_flush),
        .cycle            (cycle),
        .instret          (instret)
    );

    csr_access u_access (
        .csr              (csr),
        .write_op         (write_op),
        .src              (src),
        .rs1_value        (rs1_value),
        .imm_value        (imm_value),
        .mstatus_mie      (mstatus_mie),
        .mstatus_mpie     (mstatus_mpie),
        .mie_bits         (mie_bits),
        .mtvec_base       (mtvec_base),
        .mtvec_mode       (mtvec_mode),
        .mscratch         (mscratch),
        .mepc             (mepc),
        .mcause_interrupt (mcause_interrupt),
        .mcause_code      (mcause_code),
        .mtval            (mtval),
        .cycle            (cycle),
        .instret          (instret),
        .read_value       (read_value),
        .new_value        (new_value)
    );

endmodule

`default_nettype wire

/* csr/csr_access.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_access (
    input  wire csr_access_pkg::csr_addr_t     csr,
    input  wire csr_access_pkg::csr_write_op_t write_op,
    input  wire csr_access_pkg::csr_src_t      src,
    input  wire logic [`CSR_XLEN-1:0]          rs1_value,
    input  wire logic [`CSR_XLEN-1:0]          imm_value,

    input  wire logic                          mstatus_mie,
    input  wire logic                          mstatus_mpie,
    input  wire logic [2:0]                    mie_bits,
    input  wire logic [`CSR_XLEN-1:2]          mtvec_base,
    input  wire csr_trap_pkg::mtvec_mode_t     mtvec_mode,
    input  wire logic [`CSR_XLEN-1:0]          mscratch,
    input  wire logic [`CSR_XLEN-1:2]          mepc,
    input  wire logic                          mcause_interrupt,
    input  wire csr_trap_pkg::mcause_code_t    mcause_code,
    input  wire logic [`CSR_XLEN-1:0]          mtval,

    input  wire logic [`CSR_COUNTER_W-1:0]     cycle,
    input  wire logic [`CSR_COUNTER_W-1:0]     instret,

    output logic [`CSR_XLEN-1:0]               read_value,
    output logic [`CSR_XLEN-1:0]               new_value
);
    import csr_access_pkg::*;

    logic [`CSR_XLEN-1:0] operand;
    logic [`CSR_XLEN-1:0] cycle_lo;
    logic [`CSR_XLEN-1:0] cycle_hi;
    logic [`CSR_XLEN-1:0] instret_lo;
    logic [`CSR_XLEN-1:0] instret_hi;

    assign operand = (src == CSR_SRC_REG) ? rs1_value : imm_value;

    assign cycle_lo   = cycle[`CSR_XLEN-1:0];
    assign cycle_hi   = cycle[`CSR_COUNTER_W-1:`CSR_XLEN];
    assign instret_lo = instret[`CSR_XLEN-1:0];
    assign instret_hi = instret[`CSR_COUNTER_W-1:`CSR_XLEN];

    // ##############################
    // Read multiplexer
    // ##############################

    always_comb begin
        read_value = '0;

        case (csr)
            CSR_MSTATUS: begin
                read_value[`CSR_BIT_MPP_LO +: 2] = `CSR_MSTATUS_MPP;  // Machine mode only.
                read_value[`CSR_BIT_MPIE]        = mstatus_mpie;
                read_value[`CSR_BIT_MIE]         = mstatus_mie;
            end
            CSR_MISA: read_value = `CSR_MISA_VALUE;
            CSR_MIE: begin
                read_value[`CSR_BIT_MEIE] = mie_bits[2];
                read_value[`CSR_BIT_MTIE] = mie_bits[1];
                read_value[`CSR_BIT_MSIE] = mie_bits[0];
            end
            CSR_MTVEC:    read_value = {mtvec_base, 1'b0, mtvec_mode};
            CSR_MSCRATCH: read_value = mscratch;
            CSR_MEPC:     read_value = {mepc, 2'b00};
            CSR_MCAUSE: begin
                read_value[`CSR_XLEN-1] = mcause_interrupt;
                read_value[3:0]         = mcause_code;
            end
            CSR_MTVAL:    read_value = mtval;

            // No interrupt sources are wired in, so nothing is ever pending.
            CSR_MIP:      read_value = '0;

            // The time alias reads the cycle count.
            CSR_MCYCLE,
            CSR_CYCLE,
            CSR_TIME:     read_value = cycle_lo;
            CSR_MCYCLEH,
            CSR_CYCLEH,
            CSR_TIMEH:    read_value = cycle_hi;
            CSR_MINSTRET,
            CSR_INSTRET:  read_value = instret_lo;
            CSR_MINSTRETH,
            CSR_INSTRETH: read_value = instret_hi;
            default:      read_value = '0;
        endcase
    end

    // ##############################
    // Read-modify-write value
    // ##############################

    always_comb begin
        case (write_op)
            CSR_OP_RW: new_value = operand;
            CSR_OP_RS: new_value = read_value | operand;
            CSR_OP_RC: new_value = read_value & ~operand;
            default:   new_value = read_value;  // Unused encoding leaves the CSR as it is.
        endcase
    end

endmodule

`default_nettype wire

/* csr/csr_counters.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_counters (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     instr_retired,
    input  wire logic                     writeback_flush,

    output logic [`CSR_COUNTER_W-1:0]     cycle,
    output logic [`CSR_COUNTER_W-1:0]     instret
);

    logic count_retire;

    // A retirement squashed at writeback never really completed.
    assign count_retire = instr_retired && !writeback_flush;

    // ##############################
    // Cycle counter
    // ##############################

    // Free running; stall and flush do not hold it.
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // ##############################
    // Retired instruction counter
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (count_retire) begin
            instret <= instret + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* csr/csr_machine_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_machine_regs (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      stall,
    input  wire logic                      flush,
    input  wire logic                      write,
    input  wire logic                      ecall,
    input  wire logic                      ebreak,
    input  wire logic                      mret,
    input  wire csr_access_pkg::csr_addr_t csr,
    input  wire logic [`CSR_XLEN-1:0]      new_value,
    input  wire logic [`CSR_XLEN-1:0]      pc,

    output logic                           mstatus_mie,
    output logic                           mstatus_mpie,
    output logic [2:0]                     mie_bits,
    output logic [`CSR_XLEN-1:2]           mtvec_base,
    output csr_trap_pkg::mtvec_mode_t      mtvec_mode,
    output logic [`CSR_XLEN-1:0]           mscratch,
    output logic [`CSR_XLEN-1:2]           mepc,
    output logic                           mcause_interrupt,
    output csr_trap_pkg::mcause_code_t     mcause_code,
    output logic [`CSR_XLEN-1:0]           mtval,
    output logic                           trap,
    output logic [`CSR_XLEN-1:0]           trap_pc
);
    import csr_access_pkg::*;
    import csr_trap_pkg::*;

    logic commit;
    logic take_exception;

    // A stalled or flushed instruction must not change any architectural state.
    assign commit         = !stall && !flush;
    assign take_exception = ecall || ebreak;

    // ##############################
    // Trap and return redirect
    // ##############################

    always_comb begin
        trap    = 1'b0;
        trap_pc = '0;

        if (commit) begin
            if (take_exception) begin
                trap    = 1'b1;
                trap_pc = {mtvec_base, 2'b00};  // Exceptions go to the base in both modes.
            end else if (mret) begin
                trap    = 1'b1;
                trap_pc = {mepc, 2'b00};
            end
        end
    end

    // ##############################
    // Register updates
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie      <= 1'b0;
            mstatus_mpie     <= 1'b0;
            mie_bits         <= '0;
            mtvec_base       <= '0;
            mtvec_mode       <= MTVEC_DIRECT;
            mscratch         <= '0;
            mepc             <= '0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= CAUSE_INSTR_MISALIGNED;
            mtval            <= '0;
        end else if (commit) begin
            if (write) begin
                case (csr)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= new_value[`CSR_BIT_MIE];
                        mstatus_mpie <= new_value[`CSR_BIT_MPIE];
                    end
                    CSR_MIE: begin
                        mie_bits <= {new_value[`CSR_BIT_MEIE],
                                     new_value[`CSR_BIT_MTIE],
                                     new_value[`CSR_BIT_MSIE]};
                    end
                    CSR_MTVEC: begin
                        mtvec_base <= new_value[`CSR_XLEN-1:2];
                        mtvec_mode <= mtvec_mode_t'(new_value[0]);
                    end
                    CSR_MSCRATCH: mscratch <= new_value;
                    CSR_MEPC:     mepc <= new_value[`CSR_XLEN-1:2];
                    CSR_MCAUSE: begin
                        mcause_interrupt <= new_value[`CSR_XLEN-1];
                        mcause_code      <= mcause_code_t'(new_value[3:0]);
                    end
                    CSR_MTVAL:    mtval <= new_value;
                    default: ;    // Read-only or unimplemented.
                endcase
            end

            // Placed after the write so that a trap in the same cycle wins.
            if (take_exception) begin
                mepc             <= pc[`CSR_XLEN-1:2];
                mcause_interrupt <= 1'b0;
                if (ecall) begin
                    mcause_code <= CAUSE_MACHINE_ECALL;
                end else begin
                    mcause_code <= CAUSE_BREAKPOINT;
                end
            end else if (mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* common/csr_trap_pkg.sv */
`default_nettype none

package csr_trap_pkg;

    // Exception codes. Interrupt causes reuse the same code space with
    // the mcause interrupt bit set.
    typedef enum logic [3:0] {
        CAUSE_INSTR_MISALIGNED = 4'd0,
        CAUSE_INSTR_FAULT      = 4'd1,
        CAUSE_ILLEGAL_INSTR    = 4'd2,
        CAUSE_BREAKPOINT       = 4'd3,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_LOAD_FAULT       = 4'd5,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_STORE_FAULT      = 4'd7,
        CAUSE_MACHINE_ECALL    = 4'd11
    } mcause_code_t;

    typedef enum logic {
        MTVEC_DIRECT   = 1'b0,
        MTVEC_VECTORED = 1'b1
    } mtvec_mode_t;

endpackage

`default_nettype wire

/* common/csr_access_pkg.sv */
`default_nettype none

`include "csr_defs.svh"

package csr_access_pkg;

    // Every CSR address the block decodes. Anything else reads as zero.
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS   = `CSR_ADDR_MSTATUS,
        CSR_MISA      = `CSR_ADDR_MISA,
        CSR_MIE       = `CSR_ADDR_MIE,
        CSR_MTVEC     = `CSR_ADDR_MTVEC,
        CSR_MSCRATCH  = `CSR_ADDR_MSCRATCH,
        CSR_MEPC      = `CSR_ADDR_MEPC,
        CSR_MCAUSE    = `CSR_ADDR_MCAUSE,
        CSR_MTVAL     = `CSR_ADDR_MTVAL,
        CSR_MIP       = `CSR_ADDR_MIP,
        CSR_MCYCLE    = `CSR_ADDR_MCYCLE,
        CSR_MINSTRET  = `CSR_ADDR_MINSTRET,
        CSR_MCYCLEH   = `CSR_ADDR_MCYCLEH,
        CSR_MINSTRETH = `CSR_ADDR_MINSTRETH,
        CSR_CYCLE     = `CSR_ADDR_CYCLE,
        CSR_TIME      = `CSR_ADDR_TIME,
        CSR_INSTRET   = `CSR_ADDR_INSTRET,
        CSR_CYCLEH    = `CSR_ADDR_CYCLEH,
        CSR_TIMEH     = `CSR_ADDR_TIMEH,
        CSR_INSTRETH  = `CSR_ADDR_INSTRETH
    } csr_addr_t;

    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b00,  // Replace.
        CSR_OP_RS = 2'b01,  // Set bits.
        CSR_OP_RC = 2'b10   // Clear bits.
    } csr_write_op_t;

    typedef enum logic {
        CSR_SRC_IMM = 1'b0,
        CSR_SRC_REG = 1'b1
    } csr_src_t;

endpackage

`default_nettype wire

/* common/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// ##############################
// Widths
// ##############################

`define CSR_XLEN       32
`define CSR_ADDR_W     12
`define CSR_COUNTER_W  64

// MXL = 1 (XLEN 32) in bits 31:30, and only the I extension in bit 8.
`define CSR_MISA_VALUE 32'h4000_0100

// ##############################
// Field bit positions
// ##############################

`define CSR_BIT_MIE     3   // mstatus.
`define CSR_BIT_MPIE    7   // mstatus.
`define CSR_BIT_MPP_LO  11  // mstatus, MPP occupies bits 12:11.
`define CSR_MSTATUS_MPP 2'b11

`define CSR_BIT_MSIE    3   // mie.
`define CSR_BIT_MTIE    7   // mie.
`define CSR_BIT_MEIE    11  // mie.

// ##############################
// CSR addresses
// ##############################

`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343
`define CSR_ADDR_MIP       12'h344
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82
`define CSR_ADDR_CYCLE     12'hC00
`define CSR_ADDR_TIME      12'hC01
`define CSR_ADDR_INSTRET   12'hC02
`define CSR_ADDR_CYCLEH    12'hC80
`define CSR_ADDR_TIMEH     12'hC81
`define CSR_ADDR_INSTRETH  12'hC82

`endif
